//--- common/core_pkg.sv
/*
 * core package: datapath widths, memory bus request, sequencer states
 * and the values the core takes on reset
 */
package core_pkg;

        typedef logic [7:0]  byte_t;
        typedef logic [15:0] addr_t;

        // first opcode fetch after reset, the core has no reset vector
        localparam addr_t start_addr = 16'h0200;

        // A, X and the opcode register all come up cleared
        localparam byte_t byte_reset = 8'h00;

        typedef enum logic [2:0] {
                fetch,
                operand_lo,
                operand_hi,
                mem_read,
                execute,
                store,
                halt
        } seq_state_e;

        // read_write is high for a read, a write lands at the end of a low cycle
        typedef struct packed {
                addr_t addr;
                byte_t wdata;
                logic  read_write;
        } bus_req_t;

endpackage

//--- common/isa_pkg.sv
/*
 * instruction set package: opcode fields, operation and addressing-mode
 * encodings and the decoded-instruction record
 */
package isa_pkg;

        typedef logic [7:0] opcode_t;
        typedef logic [2:0] bbb_t;

        // operation code is {aaa, cc}
        typedef logic [4:0] group_op_t;

        localparam group_op_t op_ora = 5'b000_01;
        localparam group_op_t op_and = 5'b001_01;
        localparam group_op_t op_eor = 5'b010_01;
        localparam group_op_t op_adc = 5'b011_01;
        localparam group_op_t op_sta = 5'b100_01;
        localparam group_op_t op_lda = 5'b101_01;
        localparam group_op_t op_cmp = 5'b110_01;
        localparam group_op_t op_sbc = 5'b111_01;
        localparam group_op_t op_stx = 5'b100_10;
        localparam group_op_t op_ldx = 5'b101_10;
        localparam group_op_t op_asl = 5'b000_10;
        localparam group_op_t op_rol = 5'b001_10;
        localparam group_op_t op_lsr = 5'b010_10;
        localparam group_op_t op_ror = 5'b011_10;

        // bbb values, the meaning depends on cc
        localparam bbb_t bbb_zp     = 3'b001;
        localparam bbb_t bbb_abs    = 3'b011;
        localparam bbb_t bbb_imm_01 = 3'b010;
        localparam bbb_t bbb_imm_10 = 3'b000;
        localparam bbb_t bbb_acc    = 3'b010;

        typedef enum logic [3:0] {
                alu_or, alu_and, alu_eor, alu_adc, alu_sbc, alu_cmp,
                alu_asl, alu_lsr, alu_rol, alu_ror, alu_pass
        } alu_op_e;

        typedef enum logic [1:0] {mode_acc, mode_imm, mode_zp, mode_abs} addr_mode_e;

        typedef enum logic [1:0] {dest_none, dest_a, dest_x, dest_mem} dest_e;

        // for stores src names the register that goes out on the bus
        typedef enum logic {src_mem, src_x} src_e;

        typedef struct packed {
                alu_op_e    alu_op;
                addr_mode_e mode;
                dest_e      dest;
                src_e       src;
                logic       writes_carry;
                logic       is_store;
                logic       illegal;
        } decoded_t;

endpackage

//--- hw/decoder/decoder.sv
/*
 * opcode decoder: holds the fetched opcode and splits it into the
 * aaa, bbb and cc fields to produce the datapath controls
 */
`timescale 1ns/10ps

module decoder import core_pkg::*, isa_pkg::*; (
        input  logic     clk,
        input  logic     reset_n,
        input  logic     opcode_load,
        input  byte_t    rdata,
        output decoded_t decoded
);

        opcode_t opcode_q;

        always_ff @(posedge clk) begin
                if (!reset_n)
                        opcode_q <= byte_reset;
                else if (opcode_load)
                        opcode_q <= rdata;
        end

        always_comb begin
                group_op_t group_op;
                bbb_t      bbb;
                logic      bad_mode;

                group_op = {opcode_q[7:5], opcode_q[1:0]};
                bbb      = opcode_q[4:2];
                bad_mode = 1'b0;

                decoded = '{alu_op: alu_pass, mode: mode_imm, dest: dest_none,
                            src: src_mem, writes_carry: 1'b0, is_store: 1'b0,
                            illegal: 1'b0};

                // addressing mode from bbb, cc=01 and cc=10 map bbb differently
                if (opcode_q[1:0] == 2'b01) begin
                        case (bbb)
                        bbb_imm_01: decoded.mode = mode_imm;
                        bbb_zp:     decoded.mode = mode_zp;
                        bbb_abs:    decoded.mode = mode_abs;
                        default:    bad_mode = 1'b1;
                        endcase
                end else begin
                        case (bbb)
                        bbb_imm_10: decoded.mode = mode_imm;
                        bbb_zp:     decoded.mode = mode_zp;
                        bbb_acc:    decoded.mode = mode_acc;
                        default:    bad_mode = 1'b1;
                        endcase
                end

                case (group_op)
                op_ora: {decoded.alu_op, decoded.dest} = {alu_or, dest_a};
                op_and: {decoded.alu_op, decoded.dest} = {alu_and, dest_a};
                op_eor: {decoded.alu_op, decoded.dest} = {alu_eor, dest_a};
                op_lda: {decoded.alu_op, decoded.dest} = {alu_pass, dest_a};
                op_adc, op_sbc: begin
                        decoded.alu_op       = (group_op == op_adc) ? alu_adc : alu_sbc;
                        decoded.dest         = dest_a;
                        decoded.writes_carry = 1'b1;
                end
                op_cmp: begin
                        decoded.alu_op       = alu_cmp;
                        decoded.writes_carry = 1'b1;
                end
                op_sta: begin
                        decoded.dest     = dest_mem;
                        decoded.is_store = 1'b1;
                        bad_mode         = bad_mode | (decoded.mode == mode_imm);
                end
                op_ldx: begin
                        decoded.dest = dest_x;
                        bad_mode     = bad_mode | (decoded.mode == mode_acc);
                end
                op_stx: begin
                        decoded.dest     = dest_mem;
                        decoded.src      = src_x;
                        decoded.is_store = 1'b1;
                        bad_mode         = bad_mode | (decoded.mode != mode_zp);
                end
                op_asl, op_lsr, op_rol, op_ror: begin
                        case (group_op)
                        op_asl:  decoded.alu_op = alu_asl;
                        op_lsr:  decoded.alu_op = alu_lsr;
                        op_rol:  decoded.alu_op = alu_rol;
                        default: decoded.alu_op = alu_ror;
                        endcase
                        decoded.dest         = dest_a;
                        decoded.writes_carry = 1'b1;
                        // only the accumulator forms are supported
                        bad_mode = bad_mode | (decoded.mode != mode_acc);
                end
                default: bad_mode = 1'b1;
                endcase

                decoded.illegal = bad_mode;
        end

endmodule

//--- hw/sequencer/sequencer.sv
/*
 * instruction sequencer: steps each instruction through fetch, operand,
 * memory and execute cycles and stops the core on an illegal opcode
 */
`timescale 1ns/10ps

module sequencer import core_pkg::*, isa_pkg::*; (
        input  logic     clk,
        input  logic     reset_n,
        input  decoded_t decoded,
        output logic     sync,
        output logic     halted,
        output logic     opcode_load,
        output logic     pc_inc,
        output logic     ea_lo_load,
        output logic     ea_hi_load,
        output logic     addr_sel,
        output logic     exec,
        output logic     read_write
);

        seq_state_e state_q;
        seq_state_e state;
        seq_state_e state_next;

        // the cycle after fetch is the first one with a valid decode, so the
        // registered operand_lo is refined here into execute or halt
        always_comb begin
                state = state_q;
                if (state_q == operand_lo) begin
                        if (decoded.illegal)
                                state = halt;
                        else if (decoded.mode == mode_acc || decoded.mode == mode_imm)
                                state = execute;
                end
        end

        always_comb begin
                state_next = state;
                case (state)
                fetch:      state_next = operand_lo;
                operand_lo: begin
                        if (decoded.mode == mode_abs)
                                state_next = operand_hi;
                        else if (decoded.is_store)
                                state_next = store;
                        else
                                state_next = mem_read;
                end
                operand_hi: state_next = decoded.is_store ? store : mem_read;
                halt:       state_next = halt;
                default:    state_next = fetch;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n)
                        state_q <= fetch;
                else
                        state_q <= state_next;
        end

        assign sync        = (state == fetch);
        assign opcode_load = (state == fetch);
        assign halted      = (state == halt);

        // the immediate byte is consumed in execute, an accumulator op has none
        assign pc_inc = (state inside {fetch, operand_lo, operand_hi}) ||
                        (state == execute && decoded.mode == mode_imm);

        assign ea_lo_load = (state == operand_lo);
        assign ea_hi_load = (state == operand_hi);
        assign addr_sel   = (state inside {mem_read, store});
        assign exec       = (state inside {execute, mem_read});
        assign read_write = (state != store);

endmodule

//--- hw/address_unit.sv
/*
 * address unit: program counter, effective-address register and the
 * choice between them for the bus address
 */
`timescale 1ns/10ps

module address_unit import core_pkg::*; (
        input  logic  clk,
        input  logic  reset_n,
        input  byte_t rdata,
        input  logic  pc_inc,
        input  logic  ea_lo_load,
        input  logic  ea_hi_load,
        input  logic  addr_sel,
        output addr_t addr
);

        addr_t pc_q;
        addr_t ea_q;

        always_ff @(posedge clk) begin
                if (!reset_n)
                        pc_q <= start_addr;
                else if (pc_inc)
                        pc_q <= pc_q + 16'd1;
        end

        // a low byte load starts a zero-page address, an absolute
        // operand then overwrites the high byte on the next cycle
        always_ff @(posedge clk) begin
                if (ea_lo_load)
                        ea_q <= {8'h00, rdata};
                else if (ea_hi_load)
                        ea_q[15:8] <= rdata;
        end

        assign addr = addr_sel ? ea_q : pc_q;

endmodule

//--- hw/datapath/alu.sv
/*
 * ALU: logic, add, subtract, compare and shift operations with carry
 */
`timescale 1ns/10ps

module alu import core_pkg::*, isa_pkg::*; (
        input  alu_op_e alu_op,
        input  byte_t   a,
        input  byte_t   b,
        input  logic    carry_in,
        output byte_t   result,
        output logic    carry_out
);

        logic [8:0] sum;
        byte_t      addend;
        logic       add_cin;

        // subtraction adds the inverse of b, carry set means no borrow
        assign addend  = (alu_op == alu_sbc || alu_op == alu_cmp) ? ~b : b;
        assign add_cin = (alu_op == alu_cmp) ? 1'b1 : carry_in;
        assign sum     = {1'b0, a} + {1'b0, addend} + {8'h00, add_cin};

        always_comb begin
                result    = b;
                carry_out = carry_in;
                case (alu_op)
                alu_or:  result = a | b;
                alu_and: result = a & b;
                alu_eor: result = a ^ b;
                alu_adc, alu_sbc: {carry_out, result} = sum;
                alu_cmp: begin
                        result    = a;
                        carry_out = sum[8];
                end
                alu_asl: {carry_out, result} = {a, 1'b0};
                alu_lsr: {result, carry_out} = {1'b0, a};
                alu_rol: {carry_out, result} = {a, carry_in};
                alu_ror: {result, carry_out} = {carry_in, a};
                default: result = b;
                endcase
        end

endmodule

//--- hw/datapath/reg_file.sv
/*
 * register file: accumulator, X register and carry flag, updated from
 * the ALU on exec, and the data driven out for stores
 */
`timescale 1ns/10ps

module reg_file import core_pkg::*, isa_pkg::*; (
        input  logic     clk,
        input  logic     reset_n,
        input  logic     exec,
        input  decoded_t decoded,
        input  byte_t    rdata,
        output byte_t    store_data
);

        byte_t a_q;
        byte_t x_q;
        logic  carry_q;
        byte_t alu_result;
        logic  alu_carry;

        // the second operand is always the byte on the bus
        alu i_alu (
                .alu_op    (decoded.alu_op),
                .a         (a_q),
                .b         (rdata),
                .carry_in  (carry_q),
                .result    (alu_result),
                .carry_out (alu_carry)
        );

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        a_q     <= byte_reset;
                        x_q     <= byte_reset;
                        carry_q <= 1'b0;
                end else if (exec) begin
                        case (decoded.dest)
                        dest_a:  a_q <= alu_result;
                        dest_x:  x_q <= alu_result;
                        default: ;
                        endcase
                        if (decoded.writes_carry)
                                carry_q <= alu_carry;
                end
        end

        assign store_data = (decoded.src == src_x) ? x_q : a_q;

endmodule

//--- hw/cpu6502_core.sv
/*
 * 6502 subset core top: decoder, sequencer, address unit and register
 * file joined to the byte-wide memory bus
 */
`timescale 1ns/10ps

module cpu6502_core import core_pkg::*, isa_pkg::*; (
        input  logic     clk,
        input  logic     reset_n,
        input  byte_t    rdata,
        output bus_req_t bus,
        output logic     sync,
        output logic     halted
);

        decoded_t decoded;
        logic     opcode_load;
        logic     pc_inc;
        logic     ea_lo_load;
        logic     ea_hi_load;
        logic     addr_sel;
        logic     exec;
        logic     read_write;
        addr_t    bus_addr;
        byte_t    store_data;

        decoder i_decoder (
                .clk         (clk),
                .reset_n     (reset_n),
                .opcode_load (opcode_load),
                .rdata       (rdata),
                .decoded     (decoded)
        );

        sequencer i_sequencer (
                .clk         (clk),
                .reset_n     (reset_n),
                .decoded     (decoded),
                .sync        (sync),
                .halted      (halted),
                .opcode_load (opcode_load),
                .pc_inc      (pc_inc),
                .ea_lo_load  (ea_lo_load),
                .ea_hi_load  (ea_hi_load),
                .addr_sel    (addr_sel),
                .exec        (exec),
                .read_write  (read_write)
        );

        address_unit i_address_unit (
                .clk        (clk),
                .reset_n    (reset_n),
                .rdata      (rdata),
                .pc_inc     (pc_inc),
                .ea_lo_load (ea_lo_load),
                .ea_hi_load (ea_hi_load),
                .addr_sel   (addr_sel),
                .addr       (bus_addr)
        );

        reg_file i_reg_file (
                .clk        (clk),
                .reset_n    (reset_n),
                .exec       (exec),
                .decoded    (decoded),
                .rdata      (rdata),
                .store_data (store_data)
        );

        assign bus = '{addr: bus_addr, wdata: store_data, read_write: read_write};

endmodule

//--- dv/tb_clock.sv
/*
 * testbench clock and power-on reset, 40 ns period with reset low
 * for the first 8 cycles
 */
`timescale 1ns/10ps

module tb_clock (
        output logic clk,
        output logic reset_n
);

        initial begin
                clk     = 1'b0;
                reset_n = 1'b0;
                repeat (8) @(posedge clk);
                reset_n <= 1'b1;
        end

        always #20 clk = ~clk;

endmodule

//--- dv/cpu_sva.sv
/*
 * bound assertions on the sequencer: halted is sticky, no write during
 * an opcode fetch, and fetch always lasts a single cycle
 */
`timescale 1ns/10ps

module cpu_sva import core_pkg::*; (
        input logic       clk,
        input logic       reset_n,
        input logic       sync,
        input logic       halted,
        input logic       read_write,
        input seq_state_e state_q
);

        // once stopped the core stays stopped until reset
        halted_sticky: assert property (@(posedge clk) disable iff (!reset_n)
                halted |=> halted)
                else $error("halted fell without a reset");

        no_write_on_sync: assert property (@(posedge clk) disable iff (!reset_n)
                !(sync && !read_write))
                else $error("write cycle overlaps an opcode fetch");

        fetch_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
                sync |=> state_q != fetch)
                else $error("sequencer stayed in fetch after sync");

endmodule

bind sequencer cpu_sva i_cpu_sva (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync       (sync),
        .halted     (halted),
        .read_write (read_write),
        .state_q    (state_q)
);

//--- dv/cpu_tb.sv
/*
 * testbench for the 6502 subset core with a memory model, a table of short
 * programs and their expected bus writes, and the bus and timing checks
 */
`timescale 1ns/10ps

module cpu_tb import core_pkg::*; ();

        localparam int n_rows      = 12;
        localparam int clk_period  = 40;
        localparam int row_cycles  = 60;

        typedef struct packed {
                logic [79:0] prog;
                addr_t       pre_addr0;
                byte_t       pre_data0;
                addr_t       pre_addr1;
                byte_t       pre_data1;
                logic [1:0]  n_wr;
                addr_t       wr_addr0;
                byte_t       wr_data0;
                addr_t       wr_addr1;
                byte_t       wr_data1;
        } row_t;

        logic     clk;
        logic     por_n;
        logic     row_reset_n;
        logic     reset_n;
        byte_t    rdata;
        bus_req_t bus;
        logic     sync;
        logic     halted;

        byte_t mem [0:65535];
        row_t  rows [n_rows];
        row_t  cur_row;
        logic  running;
        int    errors;
        int    cyc;
        int    wr_idx;
        bit    first;
        byte_t cur_op;
        addr_t exp_pc;

        tb_clock i_tb_clock (
                .clk     (clk),
                .reset_n (por_n)
        );

        assign reset_n = por_n & row_reset_n;
        assign rdata   = mem[bus.addr];

        cpu6502_core i_cpu6502_core (
                .clk     (clk),
                .reset_n (reset_n),
                .rdata   (rdata),
                .bus     (bus),
                .sync    (sync),
                .halted  (halted)
        );

        task automatic fail_now(input string msg);
                errors++;
                $display("[FAIL] %0t ns: %s", $time, msg);
                $display("Checks failed");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic expect_true(input logic ok, input string msg);
                assert (ok) else fail_now(msg);
        endtask

        // every byte gets a value that depends on its whole address
        task automatic fill_memory();
                for (int i = 0; i < 65536; i++)
                        mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h5a);
        endtask

        // opcode classes written out by hand from the 6502 opcode map
        function automatic bit is_legal(input byte_t op);
                return op inside {8'hA9, 8'hA5, 8'hAD, 8'h85, 8'h8D, 8'hA2, 8'hA6,
                                  8'h86, 8'h09, 8'h05, 8'h0D, 8'h29, 8'h25, 8'h2D,
                                  8'h49, 8'h45, 8'h4D, 8'h69, 8'h65, 8'h6D, 8'hE9,
                                  8'hE5, 8'hED, 8'hC9, 8'hC5, 8'hCD, 8'h0A, 8'h4A,
                                  8'h2A, 8'h6A};
        endfunction

        function automatic int op_cycles(input byte_t op);
                if (op inside {8'hA5, 8'h85, 8'hA6, 8'h86, 8'h05, 8'h25, 8'h45,
                               8'h65, 8'hC5, 8'hE5})
                        return 3;
                if (op inside {8'hAD, 8'h8D, 8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hCD,
                               8'hED})
                        return 4;
                return 2;
        endfunction

        function automatic int op_bytes(input byte_t op);
                if (op inside {8'h0A, 8'h4A, 8'h2A, 8'h6A} || !is_legal(op))
                        return 1;
                return op_cycles(op) == 4 ? 3 : 2;
        endfunction

        function automatic bit is_store(input byte_t op);
                return op inside {8'h85, 8'h8D, 8'h86};
        endfunction

        // the bus monitor samples at the rising edge
        always @(posedge clk) begin
                if (running) begin
                        if (sync) begin
                                if (!first)
                                        expect_true(cyc == op_cycles(cur_op),
                                                $sformatf("sync after %0d cycles of opcode %02h",
                                                          cyc, cur_op));
                                expect_true(bus.addr == exp_pc,
                                        $sformatf("sync at %04h, expected %04h",
                                                  bus.addr, exp_pc));
                                cur_op = rdata;
                                exp_pc = exp_pc + 16'(op_bytes(rdata));
                                cyc    = 1;
                                first  = 1'b0;
                        end else begin
                                cyc++;
                        end
                        if (is_legal(cur_op))
                                expect_true(!halted, "halted during a legal opcode");
                        else if (cyc >= 2)
                                expect_true(halted, "illegal opcode did not raise halted");
                        if (!bus.read_write) begin
                                expect_true(is_store(cur_op) && cyc == op_cycles(cur_op),
                                        $sformatf("write outside a store cycle, opcode %02h",
                                                  cur_op));
                                expect_true(wr_idx < cur_row.n_wr, "unexpected extra write");
                                expect_true(bus.addr == (wr_idx == 0 ? cur_row.wr_addr0
                                                                     : cur_row.wr_addr1),
                                        $sformatf("write address %04h is wrong", bus.addr));
                                expect_true(bus.wdata == (wr_idx == 0 ? cur_row.wr_data0
                                                                      : cur_row.wr_data1),
                                        $sformatf("write data %02h to %04h is wrong",
                                                  bus.wdata, bus.addr));
                                mem[bus.addr] <= bus.wdata;
                                wr_idx++;
                        end
                end
        end

        task automatic run_row(input int idx);
                int i;

                cur_row = rows[idx];
                @(posedge clk);
                row_reset_n <= 1'b0;
                running     <= 1'b0;
                @(posedge clk);
                fill_memory();
                for (i = 0; i < 10; i++)
                        mem[start_addr + 16'(i)] = cur_row.prog[79 - 8 * i -: 8];
                mem[start_addr + 16'd10] = 8'hFF;
                mem[cur_row.pre_addr0]   = cur_row.pre_data0;
                mem[cur_row.pre_addr1]   = cur_row.pre_data1;
                first  = 1'b1;
                cyc    = 0;
                wr_idx = 0;
                exp_pc = start_addr;
                @(posedge clk);
                row_reset_n <= 1'b1;
                running     <= 1'b1;
                @(posedge clk);
                while (!halted)
                        @(posedge clk);
                // a few more cycles to see that nothing is written after the halt
                repeat (3) @(posedge clk);
                running <= 1'b0;
                @(posedge clk);
                expect_true(wr_idx == cur_row.n_wr,
                        $sformatf("row %0d made %0d writes, expected %0d",
                                  idx, wr_idx, cur_row.n_wr));
        endtask

        initial begin
                row_reset_n = 1'b0;
                running     = 1'b0;
                errors      = 0;
                fill_memory();
                rows[0] = '{80'hA9_5C_85_40_A6_41_86_42_FF_FF, 16'h0041, 8'h3E, 16'h0000, 8'h00,
                            2'd2, 16'h0040, 8'h5C, 16'h0042, 8'h3E};
                rows[1] = '{80'hA9_F0_0D_00_30_49_AA_8D_00_31, 16'h3000, 8'h0F, 16'h0000, 8'h00,
                            2'd1, 16'h3100, 8'h55, 16'h0000, 8'h00};
                rows[2] = '{80'hA9_F0_29_3C_4D_01_30_85_50_FF, 16'h3001, 8'h0F, 16'h0000, 8'h00,
                            2'd1, 16'h0050, 8'h3F, 16'h0000, 8'h00};
                rows[3] = '{80'hA9_C8_69_50_65_60_85_61_FF_FF, 16'h0060, 8'h10, 16'h0000, 8'h00,
                            2'd1, 16'h0061, 8'h29, 16'h0000, 8'h00};
                rows[4] = '{80'hA9_50_E9_10_85_70_E9_10_85_71, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd2, 16'h0070, 8'h3F, 16'h0071, 8'h2F};
                rows[5] = '{80'hA9_40_C9_40_69_00_85_20_FF_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd1, 16'h0020, 8'h41, 16'h0000, 8'h00};
                rows[6] = '{80'hA9_30_C9_40_69_00_85_21_FF_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd1, 16'h0021, 8'h30, 16'h0000, 8'h00};
                rows[7] = '{80'hA9_81_0A_85_22_6A_85_23_FF_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd2, 16'h0022, 8'h02, 16'h0023, 8'h81};
                rows[8] = '{80'hA9_01_4A_69_00_85_24_FF_FF_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd1, 16'h0024, 8'h01, 16'h0000, 8'h00};
                rows[9] = '{80'hA9_80_2A_85_25_69_00_85_26_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                            2'd2, 16'h0025, 8'h00, 16'h0026, 8'h01};
                rows[10] = '{80'hA9_0F_09_30_2D_02_30_8D_01_31, 16'h3002, 8'hF5, 16'h0000, 8'h00,
                             2'd1, 16'h3101, 8'h35, 16'h0000, 8'h00};
                rows[11] = '{80'hA9_03_6A_85_27_69_00_85_28_FF, 16'h0000, 8'h00, 16'h0000, 8'h00,
                             2'd2, 16'h0027, 8'h01, 16'h0028, 8'h02};
                @(posedge clk);
                while (!por_n)
                        @(posedge clk);
                for (int r = 0; r < n_rows; r++)
                        run_row(r);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

        // watchdog sized from the row count plus the power-on reset
        initial begin
                #((n_rows * row_cycles + 16) * clk_period);
                $display("Watchdog expired before all rows finished");
                $display("Checks failed");
                $fatal(1, "timeout");
        end

endmodule

//--- vlog.f
common/core_pkg.sv
common/isa_pkg.sv
hw/decoder/decoder.sv
hw/sequencer/sequencer.sv
hw/address_unit.sv
hw/datapath/alu.sv
hw/datapath/reg_file.sv
hw/cpu6502_core.sv
dv/tb_clock.sv
dv/cpu_sva.sv
dv/cpu_tb.sv
